//--- verilog/e300_pkg.sv
/*
 * Shared constants: bus widths, register map, field positions,
 * response codes and interrupt stretch length
 */
package e300_pkg;

  // Bus widths
  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int STRB_W      = 4;
  localparam int IRQ_W       = 16;
  localparam int STRETCH_LEN = 8;

  // ----------------------------------------
  // Register map, byte addresses
  // ----------------------------------------
  localparam logic [ADDR_W-1:0] REG_BANDSEL = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] REG_FECTRL  = 32'h0000_0004;
  localparam logic [ADDR_W-1:0] REG_STATUS  = 32'h0000_0008;
  localparam logic [ADDR_W-1:0] REG_ID      = 32'h0000_000C;

  localparam logic [DATA_W-1:0] ID_VALUE = 32'hE300_0001;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // REG_BANDSEL fields
  localparam int TX_BANDSEL_LSB   = 0;
  localparam int TX_BANDSEL_W     = 3;
  localparam int RX1_BANDSEL_LSB  = 3;
  localparam int RX1_BANDSEL_W    = 3;
  localparam int RX2_BANDSEL_LSB  = 6;
  localparam int RX2_BANDSEL_W    = 3;
  localparam int RX1B_BANDSEL_LSB = 9;
  localparam int RX1C_BANDSEL_LSB = 11;
  localparam int RX2B_BANDSEL_LSB = 13;
  localparam int RX2C_BANDSEL_LSB = 15;
  // The four secondary band selects share one width
  localparam int RXX_BANDSEL_W    = 2;

  // REG_FECTRL fields
  localparam int TX_ENABLE_LSB = 0;
  localparam int TX_ENABLE_W   = 4;
  localparam int ANT_SEL_LSB   = 4;
  localparam int ANT_SEL_W     = 8;
  localparam int LED_LSB       = 12;
  localparam int LED_W         = 6;

  // REG_STATUS fields
  localparam int STAT_W           = 2;
  localparam int STAT_PRESS_BIT   = 0;
  localparam int STAT_RELEASE_BIT = 1;

endpackage

//--- verilog/reset_sync.sv
/*
 * Reset synchronizer, asynchronous assert and synchronous release
 */
`timescale 1ns/1ps

module reset_sync (
  input  logic bus_clk,
  input  logic sys_arst,
  output logic bus_rst
);

  logic [1:0] rst_pipe;

  // Preset on the async reset, then shift zeros in once it drops
  always_ff @(posedge bus_clk or posedge sys_arst) begin
    if (sys_arst) begin
      rst_pipe <= 2'b11;
    end else begin
      rst_pipe <= {rst_pipe[0], 1'b0};
    end
  end

  // Held for two bus_clk edges after release
  assign bus_rst = rst_pipe[1];

endmodule

//--- verilog/button_irq.sv
/*
 * Power button edge detector and interrupt pulse stretcher
 */
`timescale 1ns/1ps

module button_irq import e300_pkg::*; (
  input  logic bus_clk,
  input  logic bus_rst,
  input  logic onswitch_db,
  output logic press_pulse,
  output logic release_pulse,
  output logic press_irq,
  output logic release_irq
);

  // Button is active low, so idle history is all ones
  logic [1:0]             btn_hist;
  logic [STRETCH_LEN-1:0] press_sr;
  logic [STRETCH_LEN-1:0] release_sr;

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      btn_hist <= 2'b11;
    end else begin
      btn_hist <= {btn_hist[0], onswitch_db};
    end
  end

  // Low after two high samples is a press, mirror case is a release
  assign press_pulse   = ~onswitch_db & btn_hist[0] & btn_hist[1];
  assign release_pulse = onswitch_db & ~btn_hist[0] & ~btn_hist[1];

  // ----------------------------------------
  // Stretch each edge so the CPU sees it
  // ----------------------------------------
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      press_sr   <= '0;
      release_sr <= '0;
    end else begin
      press_sr   <= {press_sr[STRETCH_LEN-2:0], press_pulse};
      release_sr <= {release_sr[STRETCH_LEN-2:0], release_pulse};
    end
  end

  assign press_irq   = |press_sr;
  assign release_irq = |release_sr;

  a_no_dual_edge: assert property (@(posedge bus_clk) disable iff (bus_rst)
    !(press_pulse && release_pulse));

endmodule

//--- verilog/gp0_axil_slave.sv
/*
 * AXI-lite slave for the GP0 port, turns transfers into
 * single-cycle register strobes and holds responses
 */
`timescale 1ns/1ps

module gp0_axil_slave import e300_pkg::*; (
  input  logic              bus_clk,
  input  logic              bus_rst,
  // Write address and data
  input  logic [ADDR_W-1:0] awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [DATA_W-1:0] wdata,
  input  logic [STRB_W-1:0] wstrb,
  input  logic              wvalid,
  output logic              wready,
  // Write response
  output logic [1:0]        bresp,
  output logic              bvalid,
  input  logic              bready,
  // Read address and data
  input  logic [ADDR_W-1:0] araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [DATA_W-1:0] rdata,
  output logic [1:0]        rresp,
  output logic              rvalid,
  input  logic              rready,
  // Register bank side
  output logic              wr_stb,
  output logic [ADDR_W-1:0] wr_addr,
  output logic [DATA_W-1:0] wr_data,
  output logic [STRB_W-1:0] wr_strb,
  input  logic              wr_err,
  output logic              rd_stb,
  output logic [ADDR_W-1:0] rd_addr,
  input  logic [DATA_W-1:0] rd_data,
  input  logic              rd_err
);

  logic wr_ready_q;
  logic rd_ready_q;

  // ----------------------------------------
  // Write channel
  // ----------------------------------------
  // AW and W are taken together, one pulse per transfer
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      wr_ready_q <= 1'b0;
      bvalid     <= 1'b0;
    end else begin
      wr_ready_q <= awvalid && wvalid && !bvalid && !wr_ready_q;
      if (wr_stb) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // Response code is captured from the bank at the strobe
  always_ff @(posedge bus_clk) begin
    if (wr_stb) begin
      bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
    end
  end

  assign awready = wr_ready_q;
  assign wready  = wr_ready_q;
  assign wr_stb  = wr_ready_q && awvalid && wvalid;
  assign wr_addr = awaddr;
  assign wr_data = wdata;
  assign wr_strb = wstrb;

  // ----------------------------------------
  // Read channel
  // ----------------------------------------
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      rd_ready_q <= 1'b0;
      rvalid     <= 1'b0;
    end else begin
      rd_ready_q <= arvalid && !rvalid && !rd_ready_q;
      if (rd_stb) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge bus_clk) begin
    if (rd_stb) begin
      rdata <= rd_data;
      rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
    end
  end

  assign arready = rd_ready_q;
  assign rd_stb  = rd_ready_q && arvalid;
  assign rd_addr = araddr;

  // Responses hold steady under back-pressure
  a_bvalid_hold: assert property (@(posedge bus_clk) disable iff (bus_rst)
    bvalid && !bready |=> bvalid && $stable(bresp));

  a_rvalid_hold: assert property (@(posedge bus_clk) disable iff (bus_rst)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

//--- verilog/board_ctrl_regs.sv
/*
 * Board control register bank: RF front-end pins, sticky
 * button status with write-one-to-clear, and ID word
 */
`timescale 1ns/1ps

module board_ctrl_regs import e300_pkg::*; (
  input  logic                     bus_clk,
  input  logic                     bus_rst,
  input  logic                     wr_stb,
  input  logic [ADDR_W-1:0]        wr_addr,
  input  logic [DATA_W-1:0]        wr_data,
  input  logic [STRB_W-1:0]        wr_strb,
  output logic                     wr_err,
  input  logic                     rd_stb,
  input  logic [ADDR_W-1:0]        rd_addr,
  output logic [DATA_W-1:0]        rd_data,
  output logic                     rd_err,
  input  logic                     press_pulse,
  input  logic                     release_pulse,
  output logic                     irq_pending,
  output logic [TX_BANDSEL_W-1:0]  tx_bandsel,
  output logic [RX1_BANDSEL_W-1:0] rx1_bandsel,
  output logic [RX2_BANDSEL_W-1:0] rx2_bandsel,
  output logic [RXX_BANDSEL_W-1:0] rx1b_bandsel,
  output logic [RXX_BANDSEL_W-1:0] rx1c_bandsel,
  output logic [RXX_BANDSEL_W-1:0] rx2b_bandsel,
  output logic [RXX_BANDSEL_W-1:0] rx2c_bandsel,
  output logic [TX_ENABLE_W-1:0]   tx_enable,
  output logic [ANT_SEL_W-1:0]     ant_sel,
  output logic [LED_W-1:0]         led
);

  logic [DATA_W-1:0] bandsel_q;
  logic [DATA_W-1:0] fectrl_q;
  logic [STAT_W-1:0] status_q;
  logic [STAT_W-1:0] status_set;
  logic [STAT_W-1:0] status_clr;
  logic              wr_bandsel;
  logic              wr_fectrl;
  logic              wr_status;

  // Anything above the 16-byte window is unmapped
  function automatic logic unmapped(input logic [ADDR_W-1:0] addr);
    return |addr[ADDR_W-1:4];
  endfunction

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] cur,
                                                    input logic [DATA_W-1:0] din,
                                                    input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] res;
    res = cur;
    for (int i = 0; i < STRB_W; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = din[8*i +: 8];
      end
    end
    return res;
  endfunction

  // ----------------------------------------
  // Write decode
  // ----------------------------------------
  assign wr_err     = unmapped(wr_addr);
  assign wr_bandsel = wr_stb && !wr_err && (wr_addr[3:2] == REG_BANDSEL[3:2]);
  assign wr_fectrl  = wr_stb && !wr_err && (wr_addr[3:2] == REG_FECTRL[3:2]);
  assign wr_status  = wr_stb && !wr_err && (wr_addr[3:2] == REG_STATUS[3:2]);

  // Status bits all live in byte 0
  assign status_clr = (wr_status && wr_strb[0]) ? wr_data[STAT_W-1:0] : '0;

  always_comb begin
    status_set                   = '0;
    status_set[STAT_PRESS_BIT]   = press_pulse;
    status_set[STAT_RELEASE_BIT] = release_pulse;
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      bandsel_q <= '0;
      fectrl_q  <= '0;
      status_q  <= '0;
    end else begin
      if (wr_bandsel) begin
        bandsel_q <= merge_bytes(bandsel_q, wr_data, wr_strb);
      end
      if (wr_fectrl) begin
        fectrl_q <= merge_bytes(fectrl_q, wr_data, wr_strb);
      end
      // A new edge wins over a clear in the same cycle
      status_q <= (status_q & ~status_clr) | status_set;
    end
  end

  // ----------------------------------------
  // Read mux
  // ----------------------------------------
  always_comb begin
    rd_err  = unmapped(rd_addr);
    rd_data = '0;
    if (!rd_err) begin
      case (rd_addr[3:2])
        REG_BANDSEL[3:2]: rd_data = bandsel_q;
        REG_FECTRL[3:2]:  rd_data = fectrl_q;
        REG_STATUS[3:2]:  rd_data = {{(DATA_W-STAT_W){1'b0}}, status_q};
        REG_ID[3:2]:      rd_data = ID_VALUE;
        default:          rd_data = '0;
      endcase
    end
  end

  assign irq_pending = |status_q;

  // Front-end pins straight from the registers
  assign tx_bandsel   = bandsel_q[TX_BANDSEL_LSB +: TX_BANDSEL_W];
  assign rx1_bandsel  = bandsel_q[RX1_BANDSEL_LSB +: RX1_BANDSEL_W];
  assign rx2_bandsel  = bandsel_q[RX2_BANDSEL_LSB +: RX2_BANDSEL_W];
  assign rx1b_bandsel = bandsel_q[RX1B_BANDSEL_LSB +: RXX_BANDSEL_W];
  assign rx1c_bandsel = bandsel_q[RX1C_BANDSEL_LSB +: RXX_BANDSEL_W];
  assign rx2b_bandsel = bandsel_q[RX2B_BANDSEL_LSB +: RXX_BANDSEL_W];
  assign rx2c_bandsel = bandsel_q[RX2C_BANDSEL_LSB +: RXX_BANDSEL_W];
  assign tx_enable    = fectrl_q[TX_ENABLE_LSB +: TX_ENABLE_W];
  assign ant_sel      = fectrl_q[ANT_SEL_LSB +: ANT_SEL_W];
  assign led          = fectrl_q[LED_LSB +: LED_W];

  // Slave must hand over a known address with every strobe
  a_wr_addr_known: assert property (@(posedge bus_clk) disable iff (bus_rst)
    wr_stb |-> !$isunknown(wr_addr));

  a_rd_addr_known: assert property (@(posedge bus_clk) disable iff (bus_rst)
    rd_stb |-> !$isunknown(rd_addr));

endmodule

//--- verilog/e300_core.sv
/*
 * Programmable-logic core: reset, button interrupts, GP0 slave,
 * board control registers and the F2P interrupt vector
 */
`timescale 1ns/1ps

module e300_core import e300_pkg::*; (
  input  logic                     bus_clk,
  input  logic                     sys_arst,
  input  logic                     onswitch_db,
  // GP0 AXI-lite
  input  logic [ADDR_W-1:0]        awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  logic [DATA_W-1:0]        wdata,
  input  logic [STRB_W-1:0]        wstrb,
  input  logic                     wvalid,
  output logic                     wready,
  output logic [1:0]               bresp,
  output logic                     bvalid,
  input  logic                     bready,
  input  logic [ADDR_W-1:0]        araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output logic [DATA_W-1:0]        rdata,
  output logic [1:0]               rresp,
  output logic                     rvalid,
  input  logic                     rready,
  output logic [IRQ_W-1:0]         irq_f2p,
  // RF front-end
  output logic [TX_BANDSEL_W-1:0]  tx_bandsel,
  output logic [RX1_BANDSEL_W-1:0] rx1_bandsel,
  output logic [RX2_BANDSEL_W-1:0] rx2_bandsel,
  output logic [RXX_BANDSEL_W-1:0] rx1b_bandsel,
  output logic [RXX_BANDSEL_W-1:0] rx1c_bandsel,
  output logic [RXX_BANDSEL_W-1:0] rx2b_bandsel,
  output logic [RXX_BANDSEL_W-1:0] rx2c_bandsel,
  output logic [TX_ENABLE_W-1:0]   tx_enable,
  output logic [ANT_SEL_W-1:0]     ant_sel,
  output logic [LED_W-1:0]         led
);

  logic              bus_rst;
  logic              press_pulse;
  logic              release_pulse;
  logic              press_irq;
  logic              release_irq;
  logic              irq_pending;
  logic              wr_stb;
  logic [ADDR_W-1:0] wr_addr;
  logic [DATA_W-1:0] wr_data;
  logic [STRB_W-1:0] wr_strb;
  logic              wr_err;
  logic              rd_stb;
  logic [ADDR_W-1:0] rd_addr;
  logic [DATA_W-1:0] rd_data;
  logic              rd_err;

  reset_sync u_reset_sync (
    .bus_clk  (bus_clk),
    .sys_arst (sys_arst),
    .bus_rst  (bus_rst)
  );

  button_irq u_button_irq (
    .bus_clk       (bus_clk),
    .bus_rst       (bus_rst),
    .onswitch_db   (onswitch_db),
    .press_pulse   (press_pulse),
    .release_pulse (release_pulse),
    .press_irq     (press_irq),
    .release_irq   (release_irq)
  );

  gp0_axil_slave u_gp0_axil_slave (
    .bus_clk (bus_clk),
    .bus_rst (bus_rst),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .wr_stb  (wr_stb),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .wr_strb (wr_strb),
    .wr_err  (wr_err),
    .rd_stb  (rd_stb),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .rd_err  (rd_err)
  );

  board_ctrl_regs u_board_ctrl_regs (
    .bus_clk       (bus_clk),
    .bus_rst       (bus_rst),
    .wr_stb        (wr_stb),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_strb       (wr_strb),
    .wr_err        (wr_err),
    .rd_stb        (rd_stb),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .rd_err        (rd_err),
    .press_pulse   (press_pulse),
    .release_pulse (release_pulse),
    .irq_pending   (irq_pending),
    .tx_bandsel    (tx_bandsel),
    .rx1_bandsel   (rx1_bandsel),
    .rx2_bandsel   (rx2_bandsel),
    .rx1b_bandsel  (rx1b_bandsel),
    .rx1c_bandsel  (rx1c_bandsel),
    .rx2b_bandsel  (rx2b_bandsel),
    .rx2c_bandsel  (rx2c_bandsel),
    .tx_enable     (tx_enable),
    .ant_sel       (ant_sel),
    .led           (led)
  );

  // Upper interrupt lines are tied low for the CPU
  assign irq_f2p = {{(IRQ_W-3){1'b0}}, release_irq, press_irq, irq_pending};

endmodule

//--- tb/e300_checker.sv
/*
 * Checker: shadow register model, reference read function and
 * comparison of bus responses, pins and interrupt lines
 */
`timescale 1ns/1ps

module e300_checker import e300_pkg::*; (
  input  logic              bus_clk,
  input  logic              sys_arst,
  input  logic              chk_idle,
  input  logic              onswitch_db,
  input  logic [ADDR_W-1:0] awaddr,
  input  logic              awvalid,
  input  logic              awready,
  input  logic [DATA_W-1:0] wdata,
  input  logic [STRB_W-1:0] wstrb,
  input  logic              wvalid,
  input  logic              wready,
  input  logic [1:0]        bresp,
  input  logic              bvalid,
  input  logic              bready,
  input  logic [ADDR_W-1:0] araddr,
  input  logic              arvalid,
  input  logic              arready,
  input  logic [DATA_W-1:0] rdata,
  input  logic [1:0]        rresp,
  input  logic              rvalid,
  input  logic              rready,
  input  logic [IRQ_W-1:0]  irq_f2p,
  input  logic [DATA_W-1:0] bandsel_pins,
  input  logic [DATA_W-1:0] fectrl_pins,
  output int                err_count
);

  logic [DATA_W-1:0] sh_bandsel;
  logic [DATA_W-1:0] sh_fectrl;
  logic [1:0]        sh_status;
  logic [1:0]        hist;
  logic [1:0]        exp_bresp;
  logic [33:0]       exp_read;
  logic              pin_pending;
  logic              b_wait;
  logic              r_wait;
  int                stretch_cnt [2];

  // Expected {rresp, rdata} for a read of addr
  function automatic logic [33:0] ref_read(input logic [ADDR_W-1:0] addr);
    if (addr[31:4] != 28'h0) return {RESP_SLVERR, 32'h0};
    case (addr[3:2])
      2'd0:    return {RESP_OKAY, sh_bandsel};
      2'd1:    return {RESP_OKAY, sh_fectrl};
      2'd2:    return {RESP_OKAY, 30'h0, sh_status};
      default: return {RESP_OKAY, ID_VALUE};
    endcase
  endfunction

  function automatic logic [DATA_W-1:0] apply_strobes(input logic [DATA_W-1:0] old_val);
    logic [DATA_W-1:0] res;
    res = old_val;
    for (int b = 0; b < STRB_W; b++) begin
      if (wstrb[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

  task automatic mismatch(input string msg);
    $display("Mismatch at %0t: %s", $time, msg);
    err_count++;
  endtask

  always @(posedge bus_clk) begin : watch
    logic       press;
    logic       rel;
    logic [1:0] clr;
    if (sys_arst) begin
      sh_bandsel  <= '0;
      sh_fectrl   <= '0;
      sh_status   <= '0;
      hist        <= 2'b11;
      pin_pending <= 1'b0;
      b_wait      <= 1'b0;
      r_wait      <= 1'b0;
      err_count   = 0;
      stretch_cnt[0] = 0;
      stretch_cnt[1] = 0;
    end else begin
      // Button edges from the raw input history
      press = !onswitch_db && hist[0] && hist[1];
      rel   = onswitch_db && !hist[0] && !hist[1];
      hist  <= {hist[0], onswitch_db};
      clr   = 2'b00;
      pin_pending <= 1'b0;
      if (awvalid && wvalid && awready && wready) begin
        pin_pending <= 1'b1;
        if (awaddr[31:4] != 28'h0) begin
          exp_bresp <= RESP_SLVERR;
        end else begin
          exp_bresp <= RESP_OKAY;
          if (awaddr[3:2] == 2'd0) sh_bandsel <= apply_strobes(sh_bandsel);
          if (awaddr[3:2] == 2'd1) sh_fectrl <= apply_strobes(sh_fectrl);
          if (awaddr[3:2] == 2'd2 && wstrb[0]) clr = wdata[1:0];
        end
      end
      sh_status <= (sh_status & ~clr) | {rel, press};
      if (arvalid && arready) exp_read <= ref_read(araddr);

      if (bvalid && bresp != exp_bresp)
        mismatch($sformatf("bresp %0d, expected %0d", bresp, exp_bresp));
      if (rvalid && {rresp, rdata} != exp_read)
        mismatch($sformatf("read %0d/%h, expected %0d/%h", rresp, rdata,
                           exp_read[33:32], exp_read[31:0]));
      if (bvalid && awready) mismatch("write accepted while bvalid pending");
      if (rvalid && arready) mismatch("read accepted while rvalid pending");

      // A response left waiting must still be offered
      if (b_wait && !bvalid) mismatch("bvalid dropped before bready");
      if (r_wait && !rvalid) mismatch("rvalid dropped before rready");
      b_wait <= bvalid && !bready;
      r_wait <= rvalid && !rready;

      if (pin_pending && bandsel_pins != {15'h0, sh_bandsel[16:0]})
        mismatch($sformatf("band pins %h, expected %h", bandsel_pins, sh_bandsel[16:0]));
      if (pin_pending && fectrl_pins != {14'h0, sh_fectrl[17:0]})
        mismatch($sformatf("FE pins %h, expected %h", fectrl_pins, sh_fectrl[17:0]));
      if (irq_f2p[0] != |sh_status) mismatch("irq_f2p[0] differs from status");
      if (irq_f2p[15:3] != 13'h0) mismatch("irq_f2p upper bits not zero");

      // Stretched pulse lengths on irq bits 1 and 2
      for (int i = 0; i < 2; i++) begin
        if (irq_f2p[i+1]) begin
          stretch_cnt[i]++;
        end else if (stretch_cnt[i] != 0) begin
          if (stretch_cnt[i] != STRETCH_LEN)
            mismatch($sformatf("irq bit %0d high %0d cycles", i + 1, stretch_cnt[i]));
          stretch_cnt[i] = 0;
        end
      end

      if (chk_idle && (irq_f2p != '0 || bandsel_pins != '0 || fectrl_pins != '0 ||
                       bvalid || rvalid || awready || wready || arready))
        mismatch("outputs not idle after reset");
    end
  end

endmodule

//--- tb/tb_e300.sv
/*
 * Testbench top: clock, reset, AXI-lite driver, button driver
 * and per-test reporting
 */
`timescale 1ns/1ps

module tb_e300 import e300_pkg::*;;

  localparam int TMO = 200;

  logic              bus_clk;
  logic              sys_arst;
  logic              onswitch_db;
  logic              chk_idle;
  logic [ADDR_W-1:0] awaddr;
  logic              awvalid;
  logic              awready;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic              wvalid;
  logic              wready;
  logic [1:0]        bresp;
  logic              bvalid;
  logic              bready;
  logic [ADDR_W-1:0] araddr;
  logic              arvalid;
  logic              arready;
  logic [DATA_W-1:0] rdata;
  logic [1:0]        rresp;
  logic              rvalid;
  logic              rready;
  logic [IRQ_W-1:0]  irq_f2p;
  logic [2:0]        tx_bandsel;
  logic [2:0]        rx1_bandsel;
  logic [2:0]        rx2_bandsel;
  logic [1:0]        rx1b_bandsel;
  logic [1:0]        rx1c_bandsel;
  logic [1:0]        rx2b_bandsel;
  logic [1:0]        rx2c_bandsel;
  logic [3:0]        tx_enable;
  logic [7:0]        ant_sel;
  logic [5:0]        led;
  int                err_count;
  int                tb_fails;
  int                tests_run;
  int                tests_failed;
  int                last_errs;
  int                seed;

  always #2 bus_clk = ~bus_clk;

  e300_core u_e300_core (.*);

  e300_checker u_checker (
    .bus_clk(bus_clk), .sys_arst(sys_arst), .chk_idle(chk_idle), .onswitch_db(onswitch_db),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready), .wdata(wdata), .wstrb(wstrb),
    .wvalid(wvalid), .wready(wready), .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready), .rdata(rdata), .rresp(rresp),
    .rvalid(rvalid), .rready(rready), .irq_f2p(irq_f2p),
    .bandsel_pins({15'h0, rx2c_bandsel, rx2b_bandsel, rx1c_bandsel, rx1b_bandsel,
                   rx2_bandsel, rx1_bandsel, tx_bandsel}),
    .fectrl_pins({14'h0, led, ant_sel, tx_enable}),
    .err_count(err_count)
  );

  task automatic fail_wait(input string what);
    $display("Timeout while waiting for %s", what);
    tb_fails++;
  endtask

  // A held response also keeps a duplicate request waiting behind it
  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input int hold);
    int t;
    for (int n = 0; n < ((hold > 0) ? 2 : 1); n++) begin
      awaddr <= addr;
      wdata <= data;
      wstrb <= strb;
      awvalid <= 1'b1;
      wvalid <= 1'b1;
      t = 0;
      do begin
        @(posedge bus_clk);
        t++;
      end while (!awready && t < TMO);
      if (!awready) fail_wait("awready");
      if (n > 0 || hold == 0) begin
        awvalid <= 1'b0;
        wvalid <= 1'b0;
      end
      t = 0;
      do begin
        @(posedge bus_clk);
        t++;
      end while (!bvalid && t < TMO);
      if (!bvalid) fail_wait("bvalid");
      if (n == 0) repeat (hold) @(posedge bus_clk);
      bready <= 1'b1;
      @(posedge bus_clk);
      bready <= 1'b0;
    end
  endtask

  task automatic axi_read(input logic [31:0] addr, input int hold);
    int t;
    for (int n = 0; n < ((hold > 0) ? 2 : 1); n++) begin
      araddr <= addr;
      arvalid <= 1'b1;
      t = 0;
      do begin
        @(posedge bus_clk);
        t++;
      end while (!arready && t < TMO);
      if (!arready) fail_wait("arready");
      if (n > 0 || hold == 0) arvalid <= 1'b0;
      t = 0;
      do begin
        @(posedge bus_clk);
        t++;
      end while (!rvalid && t < TMO);
      if (!rvalid) fail_wait("rvalid");
      if (n == 0) repeat (hold) @(posedge bus_clk);
      rready <= 1'b1;
      @(posedge bus_clk);
      rready <= 1'b0;
    end
  endtask

  // Drive the button level, then follow its interrupt bit up and down
  task automatic button_edge(input logic level, input int irq_bit);
    int t;
    onswitch_db <= level;
    t = 0;
    do begin
      @(posedge bus_clk);
      t++;
    end while (!irq_f2p[irq_bit] && t < TMO);
    if (!irq_f2p[irq_bit]) fail_wait("button interrupt to rise");
    t = 0;
    do begin
      @(posedge bus_clk);
      t++;
    end while (irq_f2p[irq_bit] && t < TMO);
    if (irq_f2p[irq_bit]) fail_wait("button interrupt to fall");
  endtask

  task automatic end_test(input string name);
    int errs;
    repeat (3) @(posedge bus_clk);
    errs = err_count + tb_fails - last_errs;
    last_errs = err_count + tb_fails;
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("test %-12s %s (%0d errors)", name, (errs == 0) ? "ok" : "FAILED", errs);
  endtask

  initial begin
    bus_clk = 1'b0;
    sys_arst = 1'b1;
    onswitch_db = 1'b1;
    chk_idle = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    tb_fails = 0;
    tests_run = 0;
    tests_failed = 0;
    last_errs = 0;
    seed = 32'h09d48888;
    repeat (16) @(posedge bus_clk);
    sys_arst <= 1'b0;
    repeat (4) @(posedge bus_clk);
    chk_idle <= 1'b1;
    @(posedge bus_clk);
    chk_idle <= 1'b0;
    end_test("reset");

    for (int i = 0; i < 12; i++) begin
      axi_write({28'h0, 1'b0, i[0], 2'b00}, $random(seed), 4'($random(seed)), 0);
      axi_read(REG_BANDSEL, 0);
      axi_read(REG_FECTRL, 0);
    end
    end_test("regs");

    axi_read(REG_ID, 0);
    axi_write(REG_ID, 32'h1234_5678, 4'hF, 0);
    axi_read(REG_ID, 0);
    axi_write(32'h0000_0010, 32'hFFFF_FFFF, 4'hF, 0);
    axi_write(32'h8000_0004, 32'hFFFF_FFFF, 4'hF, 0);
    axi_read(32'h0000_0020, 0);
    axi_read(REG_BANDSEL, 0);
    axi_read(REG_FECTRL, 0);
    end_test("id_unmapped");

    button_edge(1'b0, 1);
    button_edge(1'b1, 2);
    axi_read(REG_STATUS, 0);
    end_test("button");

    axi_write(REG_STATUS, 32'h0, 4'hF, 0);
    axi_read(REG_STATUS, 0);
    axi_write(REG_STATUS, 32'h1, 4'hF, 0);
    axi_read(REG_STATUS, 0);
    axi_write(REG_STATUS, 32'h2, 4'hF, 0);
    axi_read(REG_STATUS, 0);
    end_test("status_clear");

    for (int i = 0; i < 6; i++) begin
      axi_write(REG_FECTRL, $random(seed), 4'hF, ($random(seed) & 7) + 1);
      axi_read(REG_FECTRL, ($random(seed) & 7) + 1);
    end
    end_test("backpressure");

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed,
             err_count + tb_fails);
    if (tests_failed == 0 && err_count + tb_fails == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
verilog/e300_pkg.sv
verilog/reset_sync.sv
verilog/button_irq.sv
verilog/gp0_axil_slave.sv
verilog/board_ctrl_regs.sv
verilog/e300_core.sv
tb/e300_checker.sv
tb/tb_e300.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the pass message shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module tb_e300 \
  --Mdir obj_dir -o sim_e300 &&
./obj_dir/sim_e300 | tee /dev/stderr | grep -q "TESTS PASSED" &&
echo "run_sim: pass" ||
{ echo "run_sim: fail"; exit 1; }
